// ==== pipelined_core.f ====
rtl/riscv_isa_pkg.sv
rtl/pipe_pkg.sv
rtl/fetch_stage.sv
rtl/register_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_unit.sv
rtl/pipelined_core.sv
tests/pipelined_core_tb.sv

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
    input  logic              CLK,
    input  logic              RESET_N,
    input  logic              stall,
    input  logic              flush,
    input  pipe_pkg::if_id_t  if_id,
    input  logic [31:0]       rs1_data,
    input  logic [31:0]       rs2_data,
    output logic [4:0]        rs1,
    output logic [4:0]        rs2,
    output pipe_pkg::id_ex_t  id_ex
);
    import riscv_isa_pkg::*;
    import pipe_pkg::*;

    instr_t      instr;
    ctrl_t       ctrl;
    alu_op_e     alu_op;
    alu_op_e     arith_op;
    logic        arith_ok;
    logic        legal;
    logic [31:0] imm;

    assign instr = if_id.instr;
    assign rs1   = instr.r.rs1;
    assign rs2   = instr.r.rs2;

    // funct3 decode shared by register and immediate arithmetic
    always_comb begin
        arith_ok = 1'b1;
        case (instr.r.funct3)
            F3_ADD_SUB: arith_op = (instr.r.opcode == OP && instr.r.funct7[5]) ? SUB : ADD;
            F3_AND:     arith_op = AND;
            F3_OR:      arith_op = OR;
            F3_SLT:     arith_op = SLT;
            default: begin
                arith_op = ADD;
                arith_ok = 1'b0;
            end
        endcase
    end

    // ==================================================
    // control and immediate
    // ==================================================

    always_comb begin
        ctrl   = '0;
        alu_op = ADD;
        imm    = {{20{instr.i.imm[11]}}, instr.i.imm};
        legal  = 1'b1;
        case (instr.r.opcode)
            OP: begin
                ctrl.reg_write = 1'b1;
                alu_op         = arith_op;
                legal          = arith_ok;
            end
            OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                alu_op         = arith_op;
                legal          = arith_ok;
            end
            LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                imm = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            BRANCH: begin
                ctrl.branch = 1'b1;
                alu_op      = SUB;                        // equality test through zero
                legal       = instr.b.funct3 == F3_BEQ || instr.b.funct3 == F3_BNE;
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.is_lui    = 1'b1;
                imm            = {instr.u.imm, 12'd0};
            end
            default: legal = 1'b0;                        // unsupported opcode becomes a bubble
        endcase
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            id_ex <= '0;
        end else begin
            id_ex.valid    <= if_id.valid && legal && !stall && !flush;
            id_ex.ctrl     <= ctrl;
            id_ex.pc       <= if_id.pc;
            id_ex.rs1_data <= rs1_data;
            id_ex.rs2_data <= rs2_data;
            id_ex.imm      <= imm;
            id_ex.rs1      <= instr.r.rs1;
            id_ex.rs2      <= instr.r.rs2;
            id_ex.rd       <= instr.r.rd;
            id_ex.alu_op   <= alu_op;
            id_ex.funct3   <= instr.r.funct3;
        end
    end

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic               CLK,
    input  logic               RESET_N,
    input  pipe_pkg::id_ex_t   id_ex,
    input  pipe_pkg::fwd_sel_e fwd_a,
    input  pipe_pkg::fwd_sel_e fwd_b,
    input  pipe_pkg::wb_t      wb,
    output pipe_pkg::ex_mem_t  ex_mem,
    output logic               redirect_valid,
    output logic [31:0]        redirect_pc
);
    import riscv_isa_pkg::*;
    import pipe_pkg::*;

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_b;
    logic [31:0] alu_out;
    logic        zero;

    function automatic logic [31:0] pick_operand(
        input fwd_sel_e    sel,
        input logic [31:0] reg_val,
        input logic [31:0] mem_val,
        input logic [31:0] wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    // ==================================================
    // operands and ALU
    // ==================================================

    always_comb begin
        op_a  = pick_operand(fwd_a, id_ex.rs1_data, ex_mem.alu_result, wb.value);
        op_b  = pick_operand(fwd_b, id_ex.rs2_data, ex_mem.alu_result, wb.value);
        alu_b = id_ex.ctrl.alu_src ? id_ex.imm : op_b;
        case (id_ex.alu_op)
            SUB:     alu_out = op_a - alu_b;
            AND:     alu_out = op_a & alu_b;
            OR:      alu_out = op_a | alu_b;
            SLT:     alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
            default: alu_out = op_a + alu_b;
        endcase
    end

    assign zero = alu_out == 32'd0;

    // branches are predicted not taken, so only a taken one redirects
    assign redirect_valid = id_ex.valid && id_ex.ctrl.branch &&
                            ((id_ex.funct3 == F3_BEQ && zero) ||
                             (id_ex.funct3 == F3_BNE && !zero));
    assign redirect_pc    = id_ex.pc + id_ex.imm;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            ex_mem <= '0;
        end else begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_result <= id_ex.ctrl.is_lui ? id_ex.imm : alu_out;
            ex_mem.store_data <= op_b;                    // forwarded rs2 for stores
            ex_mem.rd         <= id_ex.rd;
        end
    end

endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
    parameter int ADDR_SIZE = 10
) (
    input  logic                  CLK,
    input  logic                  RESET_N,
    input  logic                  stall,
    input  logic                  flush,
    input  logic [31:0]           redirect_pc,
    input  riscv_isa_pkg::instr_t imem_data,
    output logic [ADDR_SIZE-1:0]  imem_addr,
    output pipe_pkg::if_id_t      if_id
);
    import riscv_isa_pkg::*;

    logic [31:0] pc_q;
    logic [31:0] if_pc_q;     // address of the word now returning from memory
    logic        if_valid_q;
    logic [31:0] fetch_addr;

    // on a stall the returning word is read again so it stays paired with if_pc_q
    assign fetch_addr = stall ? if_pc_q : pc_q;
    assign imem_addr  = fetch_addr[ADDR_SIZE+1:2];

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc_q       <= '0;
            if_pc_q    <= '0;
            if_valid_q <= 1'b0;
        end else if (flush) begin
            pc_q       <= redirect_pc;
            if_valid_q <= 1'b0;                // word in flight belongs to the wrong path
        end else if (!stall) begin
            pc_q       <= pc_q + 32'd4;
            if_pc_q    <= pc_q;
            if_valid_q <= 1'b1;
        end
    end

    assign if_id = '{valid: if_valid_q,
                     pc:    if_pc_q,
                     instr: if_valid_q ? imem_data : NOP_INSTR};

endmodule

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
    input  pipe_pkg::if_id_t   if_id,
    input  pipe_pkg::id_ex_t   id_ex,
    input  pipe_pkg::ex_mem_t  ex_mem,
    input  pipe_pkg::wb_t      wb,
    input  logic               redirect_valid,
    output logic               stall,
    output logic               flush,
    output pipe_pkg::fwd_sel_e fwd_a,
    output pipe_pkg::fwd_sel_e fwd_b
);
    import pipe_pkg::*;

    logic [4:0] dec_rs1;
    logic [4:0] dec_rs2;
    logic       load_use;

    function automatic fwd_sel_e fwd_select(
        input logic [4:0] src,
        input ex_mem_t    mem,
        input wb_t        ret
    );
        if (mem.valid && mem.ctrl.reg_write && mem.rd != 5'd0 && mem.rd == src) begin
            return FWD_MEM;                          // younger result wins
        end
        if (ret.valid && ret.rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd_a = fwd_select(id_ex.rs1, ex_mem, wb);
    assign fwd_b = fwd_select(id_ex.rs2, ex_mem, wb);

    assign dec_rs1 = if_id.instr.r.rs1;
    assign dec_rs2 = if_id.instr.r.rs2;

    // load data is only ready in writeback, one cycle too late for execute
    assign load_use = id_ex.valid && id_ex.ctrl.mem_read && id_ex.rd != 5'd0 &&
                      if_id.valid && (id_ex.rd == dec_rs1 || id_ex.rd == dec_rs2);

    assign flush = redirect_valid;
    assign stall = load_use && !redirect_valid;

endmodule

// ==== rtl/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage #(
    parameter int ADDR_SIZE = 10
) (
    input  logic                CLK,
    input  logic                RESET_N,
    input  pipe_pkg::ex_mem_t   ex_mem,
    input  logic [31:0]         dmem_rdata,
    output pipe_pkg::dmem_req_t dmem_req,
    output pipe_pkg::wb_t       wb
);
    import pipe_pkg::*;

    mem_wb_t mem_wb;

    always_comb begin
        dmem_req.addr  = 32'(ex_mem.alu_result[ADDR_SIZE+1:2]);
        dmem_req.wdata = ex_mem.store_data;
        dmem_req.read  = ex_mem.valid && ex_mem.ctrl.mem_read;
        dmem_req.write = ex_mem.valid && ex_mem.ctrl.mem_write;
    end

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            mem_wb <= '0;
        end else begin
            mem_wb.valid      <= ex_mem.valid;
            mem_wb.reg_write  <= ex_mem.ctrl.reg_write;
            mem_wb.mem_to_reg <= ex_mem.ctrl.mem_to_reg;
            mem_wb.alu_result <= ex_mem.alu_result;
            mem_wb.rd         <= ex_mem.rd;
        end
    end

    // load data arrives from memory in this cycle
    assign wb.valid = mem_wb.valid && mem_wb.reg_write && mem_wb.rd != 5'd0;
    assign wb.rd    = mem_wb.rd;
    assign wb.value = mem_wb.mem_to_reg ? dmem_rdata : mem_wb.alu_result;

endmodule

// ==== rtl/pipe_pkg.sv ====
package pipe_pkg;

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic branch;
        logic alu_src;    // second operand is the immediate
        logic mem_to_reg;
        logic is_lui;
    } ctrl_t;

    // ==================================================
    // stage registers
    // ==================================================

    typedef struct packed {
        logic                  valid;
        logic [31:0]           pc;
        riscv_isa_pkg::instr_t instr;
    } if_id_t;

    typedef struct packed {
        logic                   valid;
        ctrl_t                  ctrl;
        logic [31:0]            pc;
        logic [31:0]            rs1_data;
        logic [31:0]            rs2_data;
        logic [31:0]            imm;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [4:0]             rd;
        riscv_isa_pkg::alu_op_e alu_op;
        logic [2:0]             funct3;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        ctrl_t       ctrl;
        logic [31:0] alu_result;
        logic [31:0] store_data;
        logic [4:0]  rd;
    } ex_mem_t;

    typedef struct packed {
        logic        valid;
        logic        reg_write;
        logic        mem_to_reg;
        logic [31:0] alu_result;
        logic [4:0]  rd;
    } mem_wb_t;

    // ==================================================
    // memory and retire ports
    // ==================================================

    typedef struct packed {
        logic [31:0] addr;  // word address
        logic [31:0] wdata;
        logic        read;
        logic        write;
    } dmem_req_t;

    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] value;
    } wb_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_MEM  = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_e;

endpackage

// ==== rtl/pipelined_core.sv ====
`timescale 1ns/1ps

module pipelined_core #(
    parameter int ADDR_SIZE = 10
) (
    input  logic                  CLK,
    input  logic                  RESET_N,
    output logic [ADDR_SIZE-1:0]  imem_addr,
    input  riscv_isa_pkg::instr_t imem_data,
    output pipe_pkg::dmem_req_t   dmem_req,
    input  logic [31:0]           dmem_rdata,
    output pipe_pkg::wb_t         retire
);
    import pipe_pkg::*;

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    wb_t         wb;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        stall;
    logic        flush;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    fwd_sel_e    fwd_a;
    fwd_sel_e    fwd_b;

    // ==================================================
    // pipeline stages
    // ==================================================

    fetch_stage #(.ADDR_SIZE(ADDR_SIZE)) u_fetch (
        .CLK(CLK), .RESET_N(RESET_N), .stall(stall), .flush(flush),
        .redirect_pc(redirect_pc), .imem_data(imem_data),
        .imem_addr(imem_addr), .if_id(if_id)
    );

    decode_stage u_decode (
        .CLK(CLK), .RESET_N(RESET_N), .stall(stall), .flush(flush),
        .if_id(if_id), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .rs1(rs1), .rs2(rs2), .id_ex(id_ex)
    );

    register_file u_regs (
        .CLK(CLK), .RESET_N(RESET_N), .rs1(rs1), .rs2(rs2), .wb(wb),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    execute_stage u_execute (
        .CLK(CLK), .RESET_N(RESET_N), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .wb(wb), .ex_mem(ex_mem), .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc)
    );

    memory_stage #(.ADDR_SIZE(ADDR_SIZE)) u_memory (
        .CLK(CLK), .RESET_N(RESET_N), .ex_mem(ex_mem), .dmem_rdata(dmem_rdata),
        .dmem_req(dmem_req), .wb(wb)
    );

    hazard_unit u_hazard (
        .if_id(if_id), .id_ex(id_ex), .ex_mem(ex_mem), .wb(wb),
        .redirect_valid(redirect_valid), .stall(stall), .flush(flush),
        .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    assign retire = wb; // retire port mirrors the register file write

endmodule

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic          CLK,
    input  logic          RESET_N,
    input  logic [4:0]    rs1,
    input  logic [4:0]    rs2,
    input  pipe_pkg::wb_t wb,
    output logic [31:0]   rs1_data,
    output logic [31:0]   rs2_data
);

    logic [31:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // write-through so decode sees a value retiring in the same cycle
    assign rs1_data = (rs1 == 5'd0) ? 32'd0 :
                      (wb.valid && wb.rd == rs1) ? wb.value : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? 32'd0 :
                      (wb.valid && wb.rd == rs2) ? wb.value : regs[rs2];

endmodule

// ==== rtl/riscv_isa_pkg.sv ====
package riscv_isa_pkg;

    // ==================================================
    // opcodes and function codes
    // ==================================================

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111
    } opcode_e;

    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, SLT} alu_op_e;

    // ==================================================
    // instruction formats
    // ==================================================

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
    } instr_t;

    localparam instr_t NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

endpackage

// ==== tests/pipelined_core_tb.sv ====
`timescale 1ns/1ps

module pipelined_core_tb;
    import riscv_isa_pkg::*;
    import pipe_pkg::*;

    localparam int ADDR_SIZE = 10;
    localparam int MEM_WORDS = 1 << ADDR_SIZE;

    logic                 CLK;
    logic                 RESET_N;
    logic [ADDR_SIZE-1:0] imem_addr;
    instr_t               imem_data;
    dmem_req_t            dmem_req;
    logic [31:0]          dmem_rdata;
    wb_t                  retire;

    instr_t      rom [MEM_WORDS];
    logic [31:0] ram [MEM_WORDS];
    wb_t         exp_wb [$];
    dmem_req_t   exp_store [$];
    int          prog_words;
    int          cycle_limit;
    int          cycles;
    int          wb_errors;
    int          store_errors;
    int          other_errors;
    int          seed_val;

    pipelined_core #(.ADDR_SIZE(ADDR_SIZE)) UUT (
        .CLK(CLK), .RESET_N(RESET_N), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .retire(retire)
    );

    always #2 CLK = ~CLK;

    // ==================================================
    // trace loading and compare tasks
    // ==================================================

    task automatic load_trace();
        int               fd;
        int               code;
        logic [7:0]       kind;
        logic [31:0]      a;
        logic [31:0]      d;
        logic [8*160-1:0] rest;
        wb_t              entry_wb;
        dmem_req_t        entry_st;
        fd = $fopen("tests/pipelined_core_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file, nothing to run");
            other_errors++;
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                break;
            end
            case (kind)
                "#": code = $fgets(rest, fd);           // comment runs to end of line
                "P": begin
                    code = $fscanf(fd, "%h %h", a, d);
                    rom[a[ADDR_SIZE-1:0]] = d;
                    prog_words++;
                end
                "W": begin
                    code = $fscanf(fd, "%d %h", a, d);
                    entry_wb.valid = 1'b1;
                    entry_wb.rd    = a[4:0];
                    entry_wb.value = d;
                    exp_wb.push_back(entry_wb);
                end
                "S": begin
                    code = $fscanf(fd, "%h %h", a, d);
                    entry_st.addr  = a;
                    entry_st.wdata = d;
                    entry_st.read  = 1'b0;
                    entry_st.write = 1'b1;
                    exp_store.push_back(entry_st);
                end
                default: begin
                    $display("trace file holds a line of unknown kind '%c'", kind);
                    other_errors++;
                    code = $fgets(rest, fd);
                end
            endcase
        end
        $fclose(fd);
    endtask

    task automatic check_wb(input wb_t actual);
        wb_t expected;
        if (exp_wb.size() == 0) begin
            $display("%0t: x%0d retired after every expected retire was seen", $time, actual.rd);
            other_errors++;
            return;
        end
        expected = exp_wb.pop_front();
        if (actual !== expected) begin
            $display("Fail at %0t: retire expected x%0d=%h, got x%0d=%h", $time,
                     expected.rd, expected.value, actual.rd, actual.value);
            wb_errors++;
        end
    endtask

    task automatic check_store(input dmem_req_t actual);
        dmem_req_t expected;
        if (exp_store.size() == 0) begin
            $display("%0t: store to word %h after every expected store was seen", $time,
                     actual.addr);
            other_errors++;
            return;
        end
        expected = exp_store.pop_front();
        if (actual !== expected) begin
            $display("Fail at %0t: dmem_req expected [%h]=%h, got [%h]=%h", $time,
                     expected.addr, expected.wdata, actual.addr, actual.wdata);
            store_errors++;
        end
    endtask

    // ==================================================
    // memory models and monitor
    // ==================================================

    always @(posedge CLK) begin
        imem_data <= rom[imem_addr];
        if (dmem_req.write) begin
            ram[dmem_req.addr[ADDR_SIZE-1:0]] <= dmem_req.wdata;
        end
        if (dmem_req.read) begin
            dmem_rdata <= ram[dmem_req.addr[ADDR_SIZE-1:0]]; // one cycle read latency
        end
    end

    always @(posedge CLK) begin
        if (!RESET_N) begin
            if (retire.valid || dmem_req.write || dmem_req.read) begin
                $display("%0t: a retire or memory access came out while reset was held",
                         $time);
                other_errors++;
            end
        end else begin
            if (retire.valid) begin
                check_wb(retire);
            end
            if (dmem_req.write) begin
                check_store(dmem_req);
            end
        end
    end

    initial begin
        CLK        = 1'b0;
        RESET_N    = 1'b0;
        imem_data  = NOP_INSTR;
        dmem_rdata = '0;
        seed_val   = $urandom(32'h5a5b7929);
        for (int i = 0; i < MEM_WORDS; i++) begin
            rom[i] = NOP_INSTR;
            ram[i] = $urandom;
        end
        load_trace();
        cycle_limit = 8 * prog_words + 100;
        repeat (16) @(posedge CLK);
        RESET_N <= 1'b1;
        cycles = 16;
        while ((exp_wb.size() != 0 || exp_store.size() != 0) && cycles < cycle_limit) begin
            @(negedge CLK);
            cycles++;
        end
        if (exp_wb.size() != 0 || exp_store.size() != 0) begin
            $display("timeout after %0d cycles, %0d retires and %0d stores never came",
                     cycles, exp_wb.size(), exp_store.size());
            other_errors++;
        end
        $display("errors: retire %0d, store %0d, other %0d", wb_errors, store_errors,
                 other_errors);
        if (wb_errors + store_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/pipelined_core_trace.txt ====
# P <rom word address hex> <instruction hex>    W <rd decimal> <value hex>
# S <ram word address hex> <store data hex>     text after # is ignored
P 00 123450B7 # lui  x1, 0x12345
P 01 00500113 # addi x2, x0, 5
P 02 FFD10193 # addi x3, x2, -3
P 03 00310233 # add  x4, x2, x3
P 04 402202B3 # sub  x5, x4, x2
P 05 0041A333 # slt  x6, x3, x4
P 06 6780E393 # ori  x7, x1, 0x678
P 07 0FF3F413 # andi x8, x7, 0xff
P 08 005464B3 # or   x9, x8, x5
P 09 00110013 # addi x0, x2, 1
P 0A FFF00513 # addi x10, x0, -1
P 0B 002525B3 # slt  x11, x10, x2
P 0C 00702823 # sw   x7, 16(x0)
P 0D 01002603 # lw   x12, 16(x0)
P 0E 002606B3 # add  x13, x12, x2
P 0F 00D02A23 # sw   x13, 20(x0)
P 10 00518663 # beq  x3, x5, +12
P 11 00100713 # addi x14, x0, 1
P 12 00200713 # addi x14, x0, 2
P 13 00519463 # bne  x3, x5, +8
P 14 00300713 # addi x14, x0, 3
P 15 00300793 # addi x15, x0, 3
P 16 00000813 # addi x16, x0, 0
P 17 00580813 # addi x16, x16, 5
P 18 FFF78793 # addi x15, x15, -1
P 19 FE079CE3 # bne  x15, x0, -8
P 1A 00700893 # addi x17, x0, 7
P 1B 00800913 # addi x18, x0, 8
P 1C 01402983 # lw   x19, 20(x0)
P 1D 01302C23 # sw   x19, 24(x0)
P 1E 00000063 # beq  x0, x0, 0
W 1 12345000
W 2 00000005
W 3 00000002
W 4 00000007
W 5 00000002
W 6 00000001
W 7 12345678
W 8 00000078
W 9 0000007A
W 10 FFFFFFFF
W 11 00000001
W 12 12345678
W 13 1234567D
W 14 00000003
W 15 00000003
W 16 00000000
W 16 00000005
W 15 00000002
W 16 0000000A
W 15 00000001
W 16 0000000F
W 15 00000000
W 17 00000007
W 18 00000008
W 19 1234567D
S 004 12345678
S 005 1234567D
S 006 1234567D
